// ==== tb.f ====
st_source_pkg.sv
st_cmd_writer.sv
st_entry_fifo.sv
st_bus_driver.sv
st_source_top.sv
tb_clock_gen.sv
tb_st_source.sv

// ==== Makefile ====
# Verilator build and run of the streaming packet source testbench.
# Any variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_st_source
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_st_source.sv ====
/*
 * Testbench for the streaming packet source.
 * Pushes random beats in three phases (ready high, ready held low,
 * random ready) and checks order, idle gaps, ready latency, responses
 * and the queue flags. Inputs change on the falling edge.
 */
`timescale 1ns/1ps

module tb_st_source;

   localparam int n_phase1    = 24;
   localparam int n_phase2    = 24;
   localparam int n_phase3    = 40;
   localparam int total_beats = n_phase1 + n_phase2 + n_phase3;
   localparam int cycle_limit = 40 * total_beats + 200;

   // ready drive modes
   localparam int ready_high = 0;
   localparam int ready_low  = 1;
   localparam int ready_rand = 2;

   typedef struct packed {
      logic [31:0]                      min_gap;
      logic                             sop;
      logic                             eop;
      logic [st_source_pkg::data_w-1:0] data;
   } exp_beat_t;

   logic                                clk;
   logic                                reset;
   logic                                push;
   logic [st_source_pkg::data_w-1:0]    push_data;
   logic                                push_sop;
   logic                                push_eop;
   logic [st_source_pkg::idle_w-1:0]    push_idles;
   logic                                src_ready;
   logic                                busy;
   logic                                overflow;
   logic                                src_valid;
   logic [st_source_pkg::data_w-1:0]    src_data;
   logic                                src_sop;
   logic                                src_eop;
   logic                                resp_valid;
   logic [st_source_pkg::resp_w-1:0]    resp_latency;
   logic                                complete;
   logic                                timeout;
   logic                                level_high_flag;
   logic                                level_low_flag;

   logic [15:0] lfsr_state = 16'd43312;
   logic        pkt_open;
   int          phase;
   exp_beat_t   exp_q[$];
   int          cmp_errors;
   int          flag_errors;
   int          xfer_count;
   int          resp_count;
   int          cycle_count;
   logic        lvl_high_seen;
   logic        busy_seen;
   int          busy_run;

   tb_clock_gen clock_gen_inst (
      .clk   (clk),
      .reset (reset)
   );

   st_source_top st_source_top_inst (
      .clk             (clk),
      .reset           (reset),
      .push            (push),
      .push_data       (push_data),
      .push_sop        (push_sop),
      .push_eop        (push_eop),
      .push_idles      (push_idles),
      .src_ready       (src_ready),
      .busy            (busy),
      .overflow        (overflow),
      .src_valid       (src_valid),
      .src_data        (src_data),
      .src_sop         (src_sop),
      .src_eop         (src_eop),
      .resp_valid      (resp_valid),
      .resp_latency    (resp_latency),
      .complete        (complete),
      .timeout         (timeout),
      .level_high_flag (level_high_flag),
      .level_low_flag  (level_low_flag)
   );

   // ----------------------------------------
   // random source and reference model
   // ----------------------------------------
   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic exp_beat_t expect_beat(input logic [31:0] data, input logic sop,
                                             input logic eop, input logic [7:0] idles);
      exp_beat_t e;
      // payload reaches the bus unchanged
      e.data    = data;
      e.sop     = sop;
      e.eop     = eop;
      // an idle run of n keeps valid low for at least n cycles
      e.min_gap = 32'(idles);
      return e;
   endfunction

   // ----------------------------------------
   // stimulus
   // ----------------------------------------
   task automatic drive_step(input logic want_push, input int ready_mode,
                             output logic pushed);
      logic [31:0] bits;
      @(negedge clk);
      case (ready_mode)
         ready_high: src_ready = 1'b1;
         ready_low:  src_ready = 1'b0;
         default: begin
            // ready high three times in four
            bits      = take_bits(2);
            src_ready = (bits[1:0] != 2'b00);
         end
      endcase
      // busy only moves on the rising edge so a push here is always taken
      pushed = want_push && !busy;
      if (pushed) begin
         push_data  = take_bits(st_source_pkg::data_w);
         bits       = take_bits(3);
         push_idles = {6'b0, bits[1:0]};
         push_sop   = ~pkt_open;
         push_eop   = bits[2];
         pkt_open   = ~bits[2];
         push       = 1'b1;
      end else begin
         push       = 1'b0;
         push_data  = '0;
         push_sop   = 1'b0;
         push_eop   = 1'b0;
         push_idles = '0;
      end
   endtask

   task automatic push_beats(input int n, input int ready_mode, input logic gaps);
      int          done;
      logic        want;
      logic        pushed;
      logic [31:0] bits;
      done = 0;
      while (done < n) begin
         want = 1'b1;
         if (gaps) begin
            bits = take_bits(1);
            want = bits[0];
         end
         drive_step(want, ready_mode, pushed);
         if (pushed) begin
            done++;
         end
      end
   endtask

   // run until every pushed beat is out and answered
   task automatic wait_drained(input int ready_mode);
      logic pushed;
      // one edge first so the last push is in the reference list
      drive_step(1'b0, ready_mode, pushed);
      while (exp_q.size() != 0 || resp_count != xfer_count) begin
         drive_step(1'b0, ready_mode, pushed);
      end
      repeat (2) drive_step(1'b0, ready_mode, pushed);
   endtask

   task automatic check_level(input string name, input logic expected, input logic actual);
      assert (actual == expected) else begin
         flag_errors++;
         $display("[ERROR] %0t %s expected %0b actual %0b", $time, name, expected, actual);
      end
   endtask

   initial begin
      int   n_low;
      logic pushed;
      phase       = 0;
      push        = 1'b0;
      push_data   = '0;
      push_sop    = 1'b0;
      push_eop    = 1'b0;
      push_idles  = '0;
      src_ready   = 1'b1;
      pkt_open    = 1'b0;
      flag_errors = 0;
      @(negedge reset);

      // ready held high with no back-pressure expected
      phase = 1;
      push_beats(n_phase1, ready_high, 1'b0);
      wait_drained(ready_high);

      // ready low for 30 cycles while pushing
      phase = 2;
      n_low = 0;
      repeat (30) begin
         drive_step(n_low < n_phase2, ready_low, pushed);
         if (pushed) begin
            n_low++;
         end
      end
      push_beats(n_phase2 - n_low, ready_high, 1'b0);
      wait_drained(ready_high);
      assert (lvl_high_seen) else begin
         flag_errors++;
         $display("%0t: level_high_flag never rose while src_ready was held low", $time);
      end
      assert (busy_seen) else begin
         flag_errors++;
         $display("%0t: busy never held off the pusher while src_ready was low", $time);
      end
      check_level("complete", 1'b1, complete);
      check_level("timeout", 1'b0, timeout);
      check_level("level_low_flag", 1'b1, level_low_flag);

      // random ready and random push gaps
      phase = 3;
      push_beats(n_phase3, ready_rand, 1'b1);
      wait_drained(ready_rand);
      check_level("complete", 1'b1, complete);
      check_level("timeout", 1'b0, timeout);
      check_level("overflow", 1'b0, overflow);

      $display("transfers %0d, responses %0d, compare errors %0d, flag errors %0d",
               xfer_count, resp_count, cmp_errors, flag_errors);
      if (cmp_errors + flag_errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // ----------------------------------------
   // compare
   // ----------------------------------------
   task automatic report_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      cmp_errors++;
      $display("[ERROR] %0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
   endtask

   logic [8:0] rdy_hist;
   logic       qual_rdy;
   logic       xfer;
   logic       xfer_prev;
   int         qlow;
   int         low_gap;
   int         lat_bound;
   exp_beat_t  e;

   always @(posedge clk) begin
      if (reset) begin
         rdy_hist      = '0;
         xfer_prev     = 1'b0;
         qlow          = 0;
         low_gap       = 0;
         lat_bound     = 0;
         cmp_errors    = 0;
         xfer_count    = 0;
         resp_count    = 0;
         lvl_high_seen = 1'b0;
         busy_seen     = 1'b0;
         busy_run      = 0;
         exp_q.delete();
      end else begin
         // reference list grows with every accepted push
         if (push && !busy) begin
            exp_q.push_back(expect_beat(push_data, push_sop, push_eop, push_idles));
         end
         // rdy_hist[k] is src_ready from k edges back
         rdy_hist = {rdy_hist[7:0], src_ready};
         qual_rdy = rdy_hist[st_source_pkg::ready_latency];
         xfer     = src_valid && (st_source_pkg::ready_latency != 0 || src_ready);

         assert (!src_valid || qual_rdy) else report_value("src_valid", 0, 1);
         assert (!overflow) else report_value("overflow", 0, 1);
         if (!src_valid) begin
            // idle bus outputs are zero
            assert (src_data == '0) else report_value("src_data", 0, src_data);
            assert (!src_sop) else report_value("src_sop", 0, 1);
            assert (!src_eop) else report_value("src_eop", 0, 1);
         end

         // response for the transfer one edge back
         assert (resp_valid == xfer_prev) else
            report_value("resp_valid", 32'(xfer_prev), 32'(resp_valid));
         if (resp_valid) begin
            resp_count++;
            assert (int'(resp_latency) <= lat_bound) else
               report_value("resp_latency", lat_bound, 32'(resp_latency));
            if (phase == 1) begin
               assert (resp_latency == '0) else
                  report_value("resp_latency", 0, 32'(resp_latency));
            end
         end

         if (!qual_rdy) begin
            qlow++;
         end
         if (xfer) begin
            assert (exp_q.size() != 0) else begin
               cmp_errors++;
               $display("%0t: beat transferred with no pushed beat left", $time);
            end
            if (exp_q.size() != 0) begin
               e = exp_q.pop_front();
               assert (src_data == e.data) else report_value("src_data", e.data, src_data);
               assert (src_sop == e.sop) else report_value("src_sop", 32'(e.sop), 32'(src_sop));
               assert (src_eop == e.eop) else report_value("src_eop", 32'(e.eop), 32'(src_eop));
               assert (low_gap >= int'(e.min_gap)) else
                  report_value("idle cycles before beat", e.min_gap, low_gap);
            end
            xfer_count++;
            lat_bound = qlow;
            qlow      = 0;
            low_gap   = 0;
         end else if (!src_valid) begin
            low_gap++;
         end
         xfer_prev = xfer;

         // back-pressure phase watch
         if (busy) begin
            busy_run++;
         end else begin
            busy_run = 0;
         end
         if (phase == 2 && level_high_flag) begin
            lvl_high_seen = 1'b1;
         end
         // an idle entry alone raises busy for a single cycle
         if (phase == 2 && busy_run > 1) begin
            busy_seen = 1'b1;
         end
      end
   end

   // ----------------------------------------
   // run limit
   // ----------------------------------------
   initial cycle_count = 0;

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= cycle_limit) begin
         $display("%0t: run did not finish within %0d cycles", $time, cycle_limit);
         $display("transfers %0d, responses %0d, compare errors %0d, flag errors %0d",
                  xfer_count, resp_count, cmp_errors, flag_errors);
         $display("Test FAILED");
         $finish;
      end
   end

endmodule

// ==== tb_clock_gen.sv ====
/*
 * Testbench clock and reset source.
 * Free-running 40 ns clock; reset is held high for the first 4 cycles
 * and released on a falling edge, away from the sampling edge.
 */
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk,
   output logic reset
);

   // half period of 20 ns
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

// ==== st_source_top.sv ====
/*
 * Streaming packet source top level.
 * Push side feeds the command writer, the entry fifo decouples it from
 * the bus driver, and the driver runs the valid/ready source bus.
 */
`timescale 1ns/1ps

module st_source_top (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                push,
   input  logic [st_source_pkg::data_w-1:0]    push_data,
   input  logic                                push_sop,
   input  logic                                push_eop,
   input  logic [st_source_pkg::idle_w-1:0]    push_idles,
   input  logic                                src_ready,
   output logic                                busy,
   output logic                                overflow,
   output logic                                src_valid,
   output logic [st_source_pkg::data_w-1:0]    src_data,
   output logic                                src_sop,
   output logic                                src_eop,
   output logic                                resp_valid,
   output logic [st_source_pkg::resp_w-1:0]    resp_latency,
   output logic                                complete,
   output logic                                timeout,
   output logic                                level_high_flag,
   output logic                                level_low_flag
);

   // ----------------------------------------
   // writer to fifo
   // ----------------------------------------
   logic                               wr_en;
   logic [st_source_pkg::entry_w-1:0]  wr_entry;
   logic                               full;

   // fifo to driver
   logic                               rd_en;
   logic [st_source_pkg::entry_w-1:0]  rd_entry;
   logic                               empty;

   st_cmd_writer st_cmd_writer_inst (
      .clk        (clk),
      .reset      (reset),
      .push       (push),
      .push_data  (push_data),
      .push_sop   (push_sop),
      .push_eop   (push_eop),
      .push_idles (push_idles),
      .full       (full),
      .busy       (busy),
      .overflow   (overflow),
      .wr_en      (wr_en),
      .wr_entry   (wr_entry)
   );

   st_entry_fifo st_entry_fifo_inst (
      .clk             (clk),
      .reset           (reset),
      .wr_en           (wr_en),
      .wr_entry        (wr_entry),
      .rd_en           (rd_en),
      .rd_entry        (rd_entry),
      .empty           (empty),
      .full            (full),
      .level_high_flag (level_high_flag),
      .level_low_flag  (level_low_flag)
   );

   // bus side
   st_bus_driver st_bus_driver_inst (
      .clk          (clk),
      .reset        (reset),
      .rd_entry     (rd_entry),
      .empty        (empty),
      .src_ready    (src_ready),
      .rd_en        (rd_en),
      .src_valid    (src_valid),
      .src_data     (src_data),
      .src_sop      (src_sop),
      .src_eop      (src_eop),
      .resp_valid   (resp_valid),
      .resp_latency (resp_latency),
      .complete     (complete),
      .timeout      (timeout)
   );

endmodule

// ==== st_bus_driver.sv ====
/*
 * Consumer side of the packet source.
 * Pops entries from the fifo, counts down idle runs, and plays beats
 * onto the valid/ready bus with the package ready latency.
 * Reports back-pressure per beat on resp_valid/resp_latency.
 */
`timescale 1ns/1ps

module st_bus_driver (
   input  logic                                clk,
   input  logic                                reset,
   input  logic [st_source_pkg::entry_w-1:0]   rd_entry,
   input  logic                                empty,
   input  logic                                src_ready,
   output logic                                rd_en,
   output logic                                src_valid,
   output logic [st_source_pkg::data_w-1:0]    src_data,
   output logic                                src_sop,
   output logic                                src_eop,
   output logic                                resp_valid,
   output logic [st_source_pkg::resp_w-1:0]    resp_latency,
   output logic                                complete,
   output logic                                timeout
);

   st_source_pkg::st_entry_u                      head;
   logic                                          head_is_beat;
   st_source_pkg::st_entry_u                      beat_word;
   logic                                          beat_pending;
   logic [st_source_pkg::idle_w-1:0]              idle_cnt;
   logic                                          idle_done;
   logic [st_source_pkg::max_ready_latency-1:0]   ready_dly;
   logic                                          ready_q;
   logic                                          beat_active;
   logic                                          xfer;
   logic                                          slot_free;
   logic [st_source_pkg::resp_w-1:0]              bp_cnt;

   // ----------------------------------------
   // ready delay chain
   // ----------------------------------------
   // ready_dly[k] holds src_ready from k+1 cycles back
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_dly <= '0;
      end else begin
         ready_dly <= {ready_dly[st_source_pkg::max_ready_latency-2:0], src_ready};
      end
   end

   generate
      if (st_source_pkg::ready_latency == 0) begin : g_rl_zero
         assign ready_q = src_ready;
      end else begin : g_rl_delayed
         assign ready_q = ready_dly[st_source_pkg::ready_latency-1];

         // valid only where ready was seen ready_latency cycles earlier
         a_valid_qualified : assert property (
            @(posedge clk) disable iff (reset)
            src_valid |-> $past(src_ready, st_source_pkg::ready_latency));
      end
   endgenerate

   // ----------------------------------------
   // beat issue
   // ----------------------------------------
   assign idle_done   = (idle_cnt == '0);
   assign beat_active = beat_pending & idle_done;

   // at latency 0 valid waits for ready, otherwise valid only on a
   // qualified cycle, so every valid cycle transfers
   assign src_valid = beat_active & ((st_source_pkg::ready_latency == 0) | ready_q);
   assign xfer      = beat_active & ready_q;

   // idle outputs are driven to zero
   assign src_data  = src_valid ? beat_word.beat.data : '0;
   assign src_sop   = src_valid & beat_word.beat.sop;
   assign src_eop   = src_valid & beat_word.beat.eop;

   // ----------------------------------------
   // fifo pop
   // ----------------------------------------
   assign head         = rd_entry[st_source_pkg::entry_w-2:0];
   assign head_is_beat = rd_entry[st_source_pkg::entry_w-1];

   // slot opens once the held beat leaves the bus
   assign slot_free = ~beat_pending | xfer;

   // a beat may load while its idle run still counts down,
   // a new idle run only after the previous one is done
   assign rd_en = ~empty & slot_free & (head_is_beat | idle_done);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         beat_pending <= 1'b0;
         idle_cnt     <= '0;
      end else begin
         if (rd_en && head_is_beat) begin
            beat_pending <= 1'b1;
         end else if (xfer) begin
            beat_pending <= 1'b0;
         end

         if (rd_en && !head_is_beat) begin
            idle_cnt <= head.idle.count;
         end else if (!idle_done) begin
            idle_cnt <= idle_cnt - 1'b1;
         end
      end
   end

   // pending beat payload
   always_ff @(posedge clk) begin
      if (rd_en && head_is_beat) begin
         beat_word <= head;
      end
   end

   // ----------------------------------------
   // back-pressure accounting
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         bp_cnt       <= '0;
         resp_valid   <= 1'b0;
         resp_latency <= '0;
         timeout      <= 1'b0;
      end else begin
         if (rd_en && head_is_beat) begin
            bp_cnt <= '0;
         end else if (beat_active && !ready_q && (bp_cnt != '1)) begin
            // saturate rather than wrap
            bp_cnt <= bp_cnt + 1'b1;
         end

         // response one cycle after the transfer
         resp_valid <= xfer;
         if (xfer) begin
            resp_latency <= bp_cnt;
         end

         if (bp_cnt >= st_source_pkg::resp_w'(st_source_pkg::timeout_cycles)) begin
            timeout <= 1'b1;
         end
      end
   end

   // nothing queued, nothing held, no idle run left
   assign complete = empty & ~beat_pending & idle_done;

   // a stalled beat at latency 0 stays put on the bus
   a_hold_stable : assert property (
      @(posedge clk) disable iff (reset)
      (st_source_pkg::ready_latency == 0 && src_valid && !src_ready) |=>
         (src_valid && $stable(src_data) && $stable(src_sop) && $stable(src_eop)));

endmodule

// ==== st_entry_fifo.sv ====
/*
 * Entry queue between the command writer and the bus driver.
 * Circular buffer, first-word-fall-through on the read side, so the
 * head entry is always on rd_entry while empty is low.
 * Level flags come straight from the registered occupancy count.
 */
`timescale 1ns/1ps

module st_entry_fifo (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                wr_en,
   input  logic [st_source_pkg::entry_w-1:0]   wr_entry,
   input  logic                                rd_en,
   output logic [st_source_pkg::entry_w-1:0]   rd_entry,
   output logic                                empty,
   output logic                                full,
   output logic                                level_high_flag,
   output logic                                level_low_flag
);

   logic [st_source_pkg::entry_w-1:0]       mem [st_source_pkg::fifo_depth];
   logic [st_source_pkg::fifo_addr_w-1:0]   wr_ptr;
   logic [st_source_pkg::fifo_addr_w-1:0]   rd_ptr;
   logic [st_source_pkg::fifo_count_w-1:0]  count;

   // ----------------------------------------
   // storage
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_entry;
      end
   end

   // head of queue, no read latency
   assign rd_entry = mem[rd_ptr];

   // ----------------------------------------
   // pointers and occupancy
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // depth is a power of two, pointers wrap on their own
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // read and write together leave the count alone
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // ----------------------------------------
   // status
   // ----------------------------------------
   assign empty = (count == '0);
   assign full  = (count == st_source_pkg::fifo_count_w'(st_source_pkg::fifo_depth));

   // thresholds, inclusive at both ends
   assign level_high_flag =
      (count >= st_source_pkg::fifo_count_w'(st_source_pkg::level_high));
   assign level_low_flag  =
      (count <= st_source_pkg::fifo_count_w'(st_source_pkg::level_low));

   // writer and driver must respect the status flags
   a_no_write_full : assert property (
      @(posedge clk) disable iff (reset) wr_en |-> !full);

   a_no_read_empty : assert property (
      @(posedge clk) disable iff (reset) rd_en |-> !empty);

endmodule

// ==== st_cmd_writer.sv ====
/*
 * Producer side of the packet source.
 * Takes one push per cycle and writes an idle-run entry (when the push
 * asks for idles) followed by the beat entry into the entry fifo.
 * busy tells the pusher to hold off; a push during busy is dropped.
 */
`timescale 1ns/1ps

module st_cmd_writer (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                push,
   input  logic [st_source_pkg::data_w-1:0]    push_data,
   input  logic                                push_sop,
   input  logic                                push_eop,
   input  logic [st_source_pkg::idle_w-1:0]    push_idles,
   input  logic                                full,
   output logic                                busy,
   output logic                                overflow,
   output logic                                wr_en,
   output logic [st_source_pkg::entry_w-1:0]   wr_entry
);

   // one-entry stage holding the last accepted push
   logic                              stg_valid;
   // idle-run entry still owed before the beat
   logic                              stg_idle;
   logic [st_source_pkg::idle_w-1:0]  stg_idles;
   st_source_pkg::st_entry_u          stg_word;
   st_source_pkg::st_entry_u          out_word;
   logic                              accept;

   // ----------------------------------------
   // flow control
   // ----------------------------------------
   // busy while the fifo is full or the idle entry goes out first
   assign busy   = full | (stg_valid & stg_idle);
   assign accept = push & ~busy;

   // the stage drains whenever the fifo has room
   assign wr_en  = stg_valid & ~full;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         stg_valid <= 1'b0;
         stg_idle  <= 1'b0;
         overflow  <= 1'b0;
      end else begin
         // sticky on any refused push
         if (push && busy) begin
            overflow <= 1'b1;
         end
         if (accept) begin
            stg_valid <= 1'b1;
            stg_idle  <= (push_idles != '0);
         end else if (wr_en) begin
            // idle entry gone so the beat follows next cycle
            if (stg_idle) begin
               stg_idle <= 1'b0;
            end else begin
               stg_valid <= 1'b0;
            end
         end
      end
   end

   // payload capture
   always_ff @(posedge clk) begin
      if (accept) begin
         stg_word.beat.data <= push_data;
         stg_word.beat.sop  <= push_sop;
         stg_word.beat.eop  <= push_eop;
         stg_idles          <= push_idles;
      end
   end

   // ----------------------------------------
   // entry build
   // ----------------------------------------
   always_comb begin
      out_word = stg_word;
      if (stg_idle) begin
         out_word            = '0;
         out_word.idle.count = stg_idles;
      end
   end

   assign wr_entry = {~stg_idle, out_word};

endmodule

// ==== st_source_pkg.sv ====
/*
 * Shared constants and the queue word for the streaming packet source.
 * Every RTL file refers to these by scoped name, st_source_pkg::name.
 * A stored entry is one kind bit on top of an st_entry_u word.
 */
package st_source_pkg;

   // ----------------------------------------
   // bus and queue sizing
   // ----------------------------------------
   localparam int data_w            = 32;
   localparam int idle_w            = 8;
   localparam int beat_w            = data_w + 2;
   localparam int idle_pad_w        = beat_w - idle_w;

   // cycles from ready seen to valid allowed
   localparam int ready_latency     = 2;
   // length of the ready delay chain, upper bound for ready_latency
   localparam int max_ready_latency = 8;

   localparam int fifo_depth        = 16;
   localparam int fifo_addr_w       = 4;
   localparam int fifo_count_w      = 5;
   localparam int level_high        = 12;
   localparam int level_low         = 2;

   // back-pressure reporting
   localparam int resp_w            = 16;
   localparam int timeout_cycles    = 100;

   // ----------------------------------------
   // queue word
   // ----------------------------------------
   typedef struct packed {
      logic [data_w-1:0] data;
      logic              sop;
      logic              eop;
   } st_beat_t;

   // one word, two readings: a beat or an idle run
   typedef union packed {
      st_beat_t beat;
      struct packed {
         logic [idle_pad_w-1:0] pad;
         logic [idle_w-1:0]     count;
      } idle;
   } st_entry_u;

   // msb is the kind bit, 1 for beat and 0 for idle run
   localparam int entry_w = $bits(st_entry_u) + 1;

endpackage
